/* hw/blockfall_pkg.sv */
package blockfall_pkg;

    // USB HID usage codes the game reacts to
    typedef enum logic [7:0] {
        KEY_NONE = 8'h00,
        KEY_A    = 8'h04,   // Move left
        KEY_D    = 8'h07,   // Move right
        KEY_P    = 8'h13,   // Pause toggle
        KEY_R    = 8'h15,   // Restart
        KEY_S    = 8'h16,   // Soft drop
        KEY_W    = 8'h1A    // Rotate clockwise
    } key_code_e;

    typedef enum logic [1:0] {
        ST_PLAY,
        ST_PAUSED,
        ST_SPAWN
    } game_state_e;

    typedef logic [2:0]  piece_kind_t;  // I O T S Z J L
    typedef logic [1:0]  rot_t;
    typedef logic [15:0] shape_t;       // Bit row*4+col set when occupied

    localparam int FIELD_COLS = 10;
    localparam int FIELD_ROWS = 20;
    localparam int SPAWN_COL  = 3;

    // Index is kind*4 + rot, clockwise turns
    localparam shape_t SHAPES [0:27] = '{
        16'h000F, 16'h1111, 16'h000F, 16'h1111,     // I
        16'h0033, 16'h0033, 16'h0033, 16'h0033,     // O
        16'h0027, 16'h0232, 16'h0072, 16'h0131,     // T
        16'h0036, 16'h0231, 16'h0036, 16'h0231,     // S
        16'h0063, 16'h0132, 16'h0063, 16'h0132,     // Z
        16'h0071, 16'h0113, 16'h0047, 16'h0322,     // J
        16'h0074, 16'h0311, 16'h0017, 16'h0223      // L
    };

    // Top-left of the 4x4 box, in cells
    typedef struct packed {
        logic signed [4:0] col;
        logic signed [5:0] row;
    } piece_pos_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       active;     // Inside visible area
    } pixel_pos_t;

    typedef enum logic [3:0] {
        CI_BACK   = 4'd0,   // Black
        CI_BORDER = 4'd1,   // Grey
        CI_KIND0  = 4'd2,
        CI_KIND1  = 4'd3,
        CI_KIND2  = 4'd4,
        CI_KIND3  = 4'd5,
        CI_KIND4  = 4'd6,
        CI_KIND5  = 4'd7,
        CI_KIND6  = 4'd8
    } colour_idx_e;

    // Board display view of the game
    typedef struct packed {
        logic [15:0] score;
        piece_kind_t kind;
        rot_t        rot;
        piece_pos_t  pos;
        logic        paused;
        shape_t      shape;
    } game_status_t;

endpackage

/* hw/vga_timing.sv */
module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                      Clk,
    input  logic                      arst_n,
    output blockfall_pkg::pixel_pos_t pix,
    output logic                      frame_start,
    output logic                      hs,
    output logic                      vs,
    output logic                      blank_n,
    output logic                      pix_en
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    logic [9:0] hcnt;       // Pixel within line
    logic [9:0] vcnt;       // Line within frame
    logic       line_end;   // Last pixel of line, enable cycle
    logic       active;
    logic       hs_raw;
    logic       vs_raw;

    // Pixel enable, half the clock rate
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            pix_en <= 1'b0;
        end else begin
            pix_en <= ~pix_en;
        end
    end

    assign line_end = pix_en && (hcnt == 10'(H_TOTAL - 1));

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pix_en) begin
            if (line_end) begin
                hcnt <= '0;
                vcnt <= (vcnt == 10'(V_TOTAL - 1)) ? '0 : vcnt + 10'd1;   // Frame wrap
            end else begin
                hcnt <= hcnt + 10'd1;
            end
        end
    end

    assign active = (hcnt < 10'(H_ACTIVE)) && (vcnt < 10'(V_ACTIVE));
    assign hs_raw = !((hcnt >= 10'(H_ACTIVE + H_FRONT)) &&
                      (hcnt < 10'(H_ACTIVE + H_FRONT + H_SYNC)));   // Active low
    assign vs_raw = !((vcnt >= 10'(V_ACTIVE + V_FRONT)) &&
                      (vcnt < 10'(V_ACTIVE + V_FRONT + V_SYNC)));

    // Leaving the last visible line
    assign frame_start = line_end && (vcnt == 10'(V_ACTIVE - 1));

    assign pix.x      = hcnt;
    assign pix.y      = vcnt;
    assign pix.active = active;

    // One clock late to meet the render register
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            hs      <= 1'b1;
            vs      <= 1'b1;
            blank_n <= 1'b0;
        end else begin
            hs      <= hs_raw;
            vs      <= vs_raw;
            blank_n <= active;
        end
    end

endmodule

/* hw/block_mover.sv */
module block_mover #(
    parameter int FALL_FRAMES = 30
) (
    input  logic                       Clk,
    input  logic                       arst_n,
    input  logic                       frame_start,
    input  logic                       run,
    input  logic                       spawn,
    input  blockfall_pkg::piece_kind_t kind,
    input  blockfall_pkg::key_code_e   keycode,
    output blockfall_pkg::piece_pos_t  pos,
    output blockfall_pkg::rot_t        rot,
    output blockfall_pkg::shape_t      shape,
    output logic                       landed
);

    import blockfall_pkg::*;

    localparam int CNT_W = (FALL_FRAMES > 1) ? $clog2(FALL_FRAMES) : 1;
    localparam piece_pos_t SPAWN_POS = '{col: 5'(SPAWN_COL), row: '0};

    logic             step;         // Frame strobe delayed, motion cycle
    key_code_e        key_s;        // Key held at frame start
    logic [CNT_W-1:0] fall_cnt;
    piece_pos_t       pos_l;
    piece_pos_t       pos_r;
    rot_t             rot_cw;
    shape_t           shape_cw;
    piece_pos_t       mv_pos;       // After side move
    rot_t             mv_rot;       // After rotation
    shape_t           mv_shape;
    piece_pos_t       dn_pos;       // One row lower
    logic             fall_now;
    logic             can_fall;

    function automatic shape_t lookup(piece_kind_t k, rot_t r);
        if (k > 3'd6) begin
            return '0;
        end
        return SHAPES[int'(k) * 4 + int'(r)];
    endfunction

    // Every occupied cell lands inside the field
    function automatic logic fits(shape_t s, piece_pos_t p);
        int  c_abs;
        int  r_abs;
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 16; i++) begin
            c_abs = int'(p.col) + (i % 4);
            r_abs = int'(p.row) + (i / 4);
            if (s[i] && (c_abs < 0 || c_abs >= FIELD_COLS ||
                         r_abs < 0 || r_abs >= FIELD_ROWS)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    assign shape    = lookup(kind, rot);
    assign pos_l    = '{col: pos.col - 5'sd1, row: pos.row};
    assign pos_r    = '{col: pos.col + 5'sd1, row: pos.row};
    assign rot_cw   = rot + 2'd1;
    assign shape_cw = lookup(kind, rot_cw);

    // At most one side move or turn per frame
    always_comb begin
        mv_pos = pos;
        mv_rot = rot;
        case (key_s)
            KEY_A:   if (fits(shape, pos_l)) mv_pos = pos_l;
            KEY_D:   if (fits(shape, pos_r)) mv_pos = pos_r;
            KEY_W:   if (fits(shape_cw, pos)) mv_rot = rot_cw;   // Wall blocks the turn
            default: ;
        endcase
    end

    assign mv_shape = lookup(kind, mv_rot);
    assign dn_pos   = '{col: mv_pos.col, row: mv_pos.row + 6'sd1};
    assign fall_now = (key_s == KEY_S) || (fall_cnt == CNT_W'(FALL_FRAMES - 1));
    assign can_fall = fits(mv_shape, dn_pos);   // Fails only past the floor

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            step     <= 1'b0;
            key_s    <= KEY_NONE;
            pos      <= SPAWN_POS;
            rot      <= '0;
            fall_cnt <= '0;
            landed   <= 1'b0;
        end else begin
            step   <= frame_start;
            landed <= 1'b0;
            if (frame_start) begin
                key_s <= keycode;   // Once per frame
            end
            if (spawn) begin
                pos      <= SPAWN_POS;
                rot      <= '0;
                fall_cnt <= '0;
            end else if (step && run) begin
                pos <= mv_pos;
                rot <= mv_rot;
                if (fall_now) begin
                    fall_cnt <= '0;
                    if (can_fall) begin
                        pos <= dn_pos;
                    end else begin
                        landed <= 1'b1;   // Stays put until spawn
                    end
                end else begin
                    fall_cnt <= fall_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* hw/game_fsm.sv */
module game_fsm (
    input  logic                       Clk,
    input  logic                       arst_n,
    input  blockfall_pkg::key_code_e   keycode,
    input  logic                       landed,
    input  logic                       frame_start,
    output blockfall_pkg::piece_kind_t kind,
    output logic                       spawn,
    output logic                       run,
    output logic [15:0]                score,
    output logic                       paused
);

    import blockfall_pkg::*;

    game_state_e state;
    key_code_e   key_q;         // Key seen at previous frame
    logic        pause_hit;     // New press of KEY_P
    logic        restart_hit;   // New press of KEY_R
    piece_kind_t next_kind;

    assign pause_hit   = frame_start && (keycode == KEY_P) && (key_q != KEY_P);
    assign restart_hit = frame_start && (keycode == KEY_R) && (key_q != KEY_R);
    assign next_kind   = (kind == 3'd6) ? 3'd0 : kind + 3'd1;   // Seven-kind cycle

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_PLAY;
            key_q <= KEY_NONE;
            kind  <= '0;
            score <= '0;
            spawn <= 1'b0;
        end else begin
            spawn <= 1'b0;
            if (frame_start) begin
                key_q <= keycode;
            end
            if (restart_hit) begin
                state <= ST_PLAY;   // From any state
                kind  <= '0;
                score <= '0;
                spawn <= 1'b1;
            end else begin
                case (state)
                    ST_PLAY: begin
                        if (landed) begin
                            state <= ST_SPAWN;
                            kind  <= next_kind;
                            score <= score + 16'd1;
                            spawn <= 1'b1;   // High through the spawn clock
                        end else if (pause_hit) begin
                            state <= ST_PAUSED;
                        end
                    end
                    ST_PAUSED: begin
                        if (pause_hit) begin
                            state <= ST_PLAY;
                        end
                    end
                    ST_SPAWN: state <= ST_PLAY;   // Single clock
                    default:  state <= ST_PLAY;
                endcase
            end
        end
    end

    assign run    = (state == ST_PLAY);
    assign paused = (state == ST_PAUSED);

endmodule

/* hw/piece_render.sv */
module piece_render #(
    parameter int CELL_SHIFT = 4,
    parameter int FIELD_X0   = 240,
    parameter int FIELD_Y0   = 80
) (
    input  logic                       Clk,
    input  logic                       arst_n,
    input  blockfall_pkg::pixel_pos_t  pix,
    input  blockfall_pkg::piece_pos_t  pos,
    input  blockfall_pkg::shape_t      shape,
    input  blockfall_pkg::piece_kind_t kind,
    output logic [7:0]                 rgb_r,
    output logic [7:0]                 rgb_g,
    output logic [7:0]                 rgb_b
);

    import blockfall_pkg::*;

    logic signed [11:0] rel_x;      // Pixel relative to field origin
    logic signed [11:0] rel_y;
    logic signed [11:0] cell_x;     // Field cell, negative left of field
    logic signed [11:0] cell_y;
    logic signed [11:0] off_c;      // Cell inside piece box
    logic signed [11:0] off_r;
    logic               in_field;
    logic               in_ring;    // Field plus one border cell
    logic               in_box;
    logic               piece_hit;
    colour_idx_e        cidx;

    assign rel_x  = signed'({2'b00, pix.x}) - signed'(12'(FIELD_X0));
    assign rel_y  = signed'({2'b00, pix.y}) - signed'(12'(FIELD_Y0));
    assign cell_x = rel_x >>> CELL_SHIFT;   // Floor, keeps left border at -1
    assign cell_y = rel_y >>> CELL_SHIFT;

    assign in_field = (cell_x >= 0) && (cell_x < FIELD_COLS) &&
                      (cell_y >= 0) && (cell_y < FIELD_ROWS);
    assign in_ring  = (cell_x >= -1) && (cell_x <= FIELD_COLS) &&
                      (cell_y >= -1) && (cell_y <= FIELD_ROWS);

    assign off_c  = cell_x - 12'(pos.col);
    assign off_r  = cell_y - 12'(pos.row);
    assign in_box = (off_c >= 0) && (off_c < 4) && (off_r >= 0) && (off_r < 4);
    assign piece_hit = in_field && in_box && shape[{off_r[1:0], off_c[1:0]}];

    // Border, piece, then background
    always_comb begin
        if (in_ring && !in_field) begin
            cidx = CI_BORDER;
        end else if (piece_hit) begin
            cidx = colour_idx_e'(4'(CI_KIND0) + 4'(kind));
        end else begin
            cidx = CI_BACK;
        end
    end

    // Palette register, black in blanking
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            {rgb_r, rgb_g, rgb_b} <= '0;
        end else if (!pix.active) begin
            {rgb_r, rgb_g, rgb_b} <= '0;
        end else begin
            case (cidx)
                CI_BORDER: {rgb_r, rgb_g, rgb_b} <= 24'h808080;
                CI_KIND0:  {rgb_r, rgb_g, rgb_b} <= 24'h00F0F0;   // I cyan
                CI_KIND1:  {rgb_r, rgb_g, rgb_b} <= 24'hF0F000;   // O yellow
                CI_KIND2:  {rgb_r, rgb_g, rgb_b} <= 24'hA000F0;   // T purple
                CI_KIND3:  {rgb_r, rgb_g, rgb_b} <= 24'h00F000;   // S green
                CI_KIND4:  {rgb_r, rgb_g, rgb_b} <= 24'hF00000;   // Z red
                CI_KIND5:  {rgb_r, rgb_g, rgb_b} <= 24'h0000F0;   // J blue
                CI_KIND6:  {rgb_r, rgb_g, rgb_b} <= 24'hF0A000;   // L orange
                default:   {rgb_r, rgb_g, rgb_b} <= 24'h000000;
            endcase
        end
    end

endmodule

/* hw/blockfall_top.sv */
module blockfall_top #(
    parameter int H_ACTIVE    = 640,
    parameter int H_FRONT     = 16,
    parameter int H_SYNC      = 96,
    parameter int H_BACK      = 48,
    parameter int V_ACTIVE    = 480,
    parameter int V_FRONT     = 10,
    parameter int V_SYNC      = 2,
    parameter int V_BACK      = 33,
    parameter int CELL_SHIFT  = 4,
    parameter int FIELD_X0    = 240,
    parameter int FIELD_Y0    = 80,
    parameter int FALL_FRAMES = 30
) (
    input  logic                        Clk,
    input  logic                        arst_n,
    input  blockfall_pkg::key_code_e    keycode,
    output logic [7:0]                  vga_r,
    output logic [7:0]                  vga_g,
    output logic [7:0]                  vga_b,
    output logic                        vga_hs,
    output logic                        vga_vs,
    output logic                        vga_blank_n,
    output logic                        vga_sync_n,
    output logic                        vga_clk,
    output blockfall_pkg::game_status_t status
);

    import blockfall_pkg::*;

    pixel_pos_t  pix;
    logic        frame_start;
    logic        pix_en;
    piece_pos_t  pos;
    rot_t        rot;
    shape_t      shape;
    logic        landed;
    piece_kind_t kind;
    logic        spawn;
    logic        run;
    logic [15:0] score;
    logic        paused;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .Clk(Clk), .arst_n(arst_n), .pix(pix), .frame_start(frame_start),
        .hs(vga_hs), .vs(vga_vs), .blank_n(vga_blank_n), .pix_en(pix_en)
    );

    block_mover #(.FALL_FRAMES(FALL_FRAMES)) u_mover (
        .Clk(Clk), .arst_n(arst_n), .frame_start(frame_start), .run(run),
        .spawn(spawn), .kind(kind), .keycode(keycode), .pos(pos), .rot(rot),
        .shape(shape), .landed(landed)
    );

    game_fsm u_fsm (
        .Clk(Clk), .arst_n(arst_n), .keycode(keycode), .landed(landed),
        .frame_start(frame_start), .kind(kind), .spawn(spawn), .run(run),
        .score(score), .paused(paused)
    );

    piece_render #(
        .CELL_SHIFT(CELL_SHIFT), .FIELD_X0(FIELD_X0), .FIELD_Y0(FIELD_Y0)
    ) u_render (
        .Clk(Clk), .arst_n(arst_n), .pix(pix), .pos(pos), .shape(shape),
        .kind(kind), .rgb_r(vga_r), .rgb_g(vga_g), .rgb_b(vga_b)
    );

    assign vga_sync_n = 1'b0;     // No sync on green
    assign vga_clk    = pix_en;   // Clk/2 square wave

    // What the board displays would show
    assign status = '{score: score, kind: kind, rot: rot, pos: pos,
                      paused: paused, shape: shape};

endmodule

/* tb/blockfall_checker.sv */
module blockfall_checker #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_SYNC   = 2
) (
    input logic                        Clk,
    input logic                        arst_n,
    input blockfall_pkg::pixel_pos_t   pix,
    input logic [7:0]                  vga_r,
    input logic [7:0]                  vga_g,
    input logic [7:0]                  vga_b,
    input logic                        vga_hs,
    input logic                        vga_vs,
    input logic                        vga_blank_n,
    input logic                        vga_clk,
    input blockfall_pkg::game_status_t status
);

    import blockfall_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int HS_CLKS = 2 * H_SYNC;             // Two clocks per pixel
    localparam int VS_CLKS = 2 * H_TOTAL * V_SYNC;   // Whole lines

    int          fail_cnt = 0;  // Failed assertions so far
    int          hs_len;        // Clocks spent low so far
    int          vs_len;
    logic        in_area;
    logic [15:0] score_q;       // Score one clock ago
    logic        score_step;

    // Piece cells against the 10x20 field
    function automatic logic cells_inside(shape_t s, piece_pos_t p);
        int   col;
        int   row;
        logic ok;
        ok = 1'b1;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                col = int'(p.col) + c;
                row = int'(p.row) + r;
                if (s[r * 4 + c] && (col < 0 || col > FIELD_COLS - 1 ||
                                     row < 0 || row > FIELD_ROWS - 1)) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    function automatic piece_kind_t kind_after(piece_kind_t k);
        return piece_kind_t'((int'(k) + 1) % 7);   // I O T S Z J L, then I again
    endfunction

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            hs_len  <= 0;
            vs_len  <= 0;
            score_q <= '0;
        end else begin
            hs_len  <= vga_hs ? 0 : hs_len + 1;
            vs_len  <= vga_vs ? 0 : vs_len + 1;
            score_q <= status.score;
        end
    end

    assign in_area    = (pix.x < 10'(H_ACTIVE)) && (pix.y < 10'(V_ACTIVE));
    assign score_step = (status.score != score_q);

    hs_width: assert property (@(posedge Clk) disable iff (!arst_n)
        $rose(vga_hs) |-> hs_len == HS_CLKS)
        else begin fail_cnt++; $error("hsync low for %0d clocks", hs_len); end

    vs_width: assert property (@(posedge Clk) disable iff (!arst_n)
        $rose(vga_vs) |-> vs_len == VS_CLKS)
        else begin fail_cnt++; $error("vsync low for %0d clocks", vs_len); end

    // Pixel enable seen as a Clk/2 square wave
    pix_clock: assert property (@(posedge Clk) disable iff (!arst_n)
        $past(arst_n) |-> vga_clk != $past(vga_clk))
        else begin fail_cnt++; $error("vga_clk did not toggle"); end

    // Blank follows the counters one clock later
    blank_area: assert property (@(posedge Clk) disable iff (!arst_n)
        $past(arst_n) |-> vga_blank_n == $past(in_area))
        else begin fail_cnt++; $error("blank_n does not match the active area"); end

    blank_black: assert property (@(posedge Clk) disable iff (!arst_n)
        !vga_blank_n |-> {vga_r, vga_g, vga_b} == 24'h0)
        else begin fail_cnt++; $error("RGB not black during blanking"); end

    // New kind shows one clock before the box returns to spawn
    walls: assert property (@(posedge Clk) disable iff (!arst_n)
        $stable(status.kind) |-> cells_inside(status.shape, status.pos))
        else begin fail_cnt++; $error("piece cell outside the field"); end

    landing_step: assert property (@(posedge Clk) disable iff (!arst_n)
        score_step && status.score != 16'd0 |->
            status.score == $past(status.score) + 16'd1 &&
            status.kind == kind_after($past(status.kind)))
        else begin fail_cnt++; $error("landing did not step score and kind"); end

    restart_kind: assert property (@(posedge Clk) disable iff (!arst_n)
        score_step && status.score == 16'd0 |-> status.kind == '0)
        else begin fail_cnt++; $error("restart left kind nonzero"); end

    respawn: assert property (@(posedge Clk) disable iff (!arst_n)
        score_step |=> status.pos.col == 5'(SPAWN_COL) && status.pos.row == '0 &&
            status.rot == '0)
        else begin fail_cnt++; $error("new piece not at spawn"); end

    // Nothing moves while paused
    pause_hold: assert property (@(posedge Clk) disable iff (!arst_n)
        status.paused && $past(status.paused) |->
            status.pos == $past(status.pos) && status.rot == $past(status.rot) &&
            status.score == $past(status.score))
        else begin fail_cnt++; $error("game moved while paused"); end

endmodule

bind blockfall_top blockfall_checker #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_SYNC(V_SYNC)
) chk (
    .Clk(Clk), .arst_n(arst_n), .pix(pix), .vga_r(vga_r), .vga_g(vga_g),
    .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n),
    .vga_clk(vga_clk), .status(status)
);

/* tb/tb_blockfall.sv */
module tb_blockfall;

    import blockfall_pkg::*;

    localparam int H_ACTIVE    = 64;
    localparam int H_FRONT     = 4;
    localparam int H_SYNC      = 8;
    localparam int H_BACK      = 4;
    localparam int V_ACTIVE    = 48;
    localparam int V_FRONT     = 2;
    localparam int V_SYNC      = 2;
    localparam int V_BACK      = 2;
    localparam int FRAME_CLKS  = 2 * (H_ACTIVE + H_FRONT + H_SYNC + H_BACK) *
                                 (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    localparam int MAX_CYCLES  = 400 * FRAME_CLKS;   // About twice the full sequence
    localparam int LAND_FRAMES = 50;                 // Full drop takes 40 frames

    logic         Clk;
    logic         arst_n;
    key_code_e    keycode;
    logic [7:0]   vga_r;
    logic [7:0]   vga_g;
    logic [7:0]   vga_b;
    logic         vga_hs;
    logic         vga_vs;
    logic         vga_blank_n;
    logic         vga_sync_n;
    logic         vga_clk;
    game_status_t status;

    int           seed;
    int           rnd;
    int           cycles = 0;
    int           tb_errs = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           errs_at_start;
    logic [15:0]  old_score;
    piece_kind_t  old_kind;
    game_status_t held;

    blockfall_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .CELL_SHIFT(1), .FIELD_X0(8), .FIELD_Y0(2), .FALL_FRAMES(2)
    ) dut (
        .Clk(Clk), .arst_n(arst_n), .keycode(keycode), .vga_r(vga_r), .vga_g(vga_g),
        .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n),
        .vga_sync_n(vga_sync_n), .vga_clk(vga_clk), .status(status)
    );

    always #50 Clk = ~Clk;

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic int total_errors();
        return tb_errs + dut.chk.fail_cnt;   // Own checks plus bound assertions
    endfunction

    function automatic int leftmost_col(game_status_t st);
        int best;
        best = 99;
        for (int i = 0; i < 16; i++) begin
            if (st.shape[i] && (int'(st.pos.col) + i % 4) < best) begin
                best = int'(st.pos.col) + i % 4;
            end
        end
        return best;
    endfunction

    task automatic expect_true(input logic ok, input string msg);
        assert (ok) else begin
            $display("ERR %0t: %s", $time, msg);
            tb_errs++;
        end
    endtask

    // Mid vertical blank, status has settled
    task automatic next_frame();
        @(negedge vga_vs);
        @(negedge Clk);
    endtask

    task automatic press_key(input key_code_e k);
        keycode = k;
        next_frame();
        keycode = KEY_NONE;
    endtask

    task automatic expect_spawn(input string where);
        expect_true(status.pos.col == 5'(SPAWN_COL) && status.pos.row == '0 &&
                    status.rot == '0, $sformatf("%s: piece at col %0d row %0d rot %0d",
                    where, status.pos.col, status.pos.row, status.rot));
    endtask

    task automatic wait_landing(input logic [15:0] from_score);
        int n;
        n = 0;
        while (status.score == from_score && n < LAND_FRAMES) begin
            next_frame();
            n++;
        end
        if (status.score == from_score) begin
            $display("Landing not seen within %0d frames", LAND_FRAMES);
            tb_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = total_errors() - errs_at_start;
        tests_run++;
        if (n == 0) begin
            $display("Test %s ok", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, n);
        end
        errs_at_start = total_errors();
    endtask

    initial begin
        Clk     = 1'b0;
        arst_n  = 1'b0;
        keycode = KEY_NONE;
        seed    = 32'hb6331f5a;
        repeat (8) @(negedge Clk);
        arst_n        = 1'b1;
        errs_at_start = total_errors();

        // Video, checked by the bound assertions
        expect_true(status.score == 16'd0 && status.kind == '0, "reset score or kind");
        expect_spawn("reset");
        repeat (3) next_frame();
        expect_true(vga_sync_n == 1'b0, "vga_sync_n not tied low");
        finish_test("video");

        // Random side moves and turns
        repeat (40) begin
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0:    keycode = KEY_A;
                2'd1:    keycode = KEY_D;
                2'd2:    keycode = KEY_W;
                default: keycode = KEY_NONE;
            endcase
            next_frame();
        end
        press_key(KEY_R);
        keycode = KEY_A;   // Fresh I piece, three steps to the wall
        repeat (10) next_frame();
        keycode = KEY_NONE;
        expect_true(leftmost_col(status) == 0,
                    $sformatf("leftmost column %0d after holding left", leftmost_col(status)));
        finish_test("walls");

        repeat (2) begin
            old_score = status.score;
            old_kind  = status.kind;
            wait_landing(old_score);
            expect_true(status.score == old_score + 16'd1,
                        $sformatf("score %0d after %0d", status.score, old_score));
            expect_true(status.kind == piece_kind_t'((int'(old_kind) + 1) % 7),
                        $sformatf("kind %0d after %0d", status.kind, old_kind));
            expect_spawn("landing");
        end
        finish_test("landing");

        press_key(KEY_P);
        expect_true(status.paused, "paused low after pause key");
        held = status;
        repeat (6) next_frame();
        expect_true(status.pos == held.pos && status.rot == held.rot &&
                    status.score == held.score, "piece or score changed in pause");
        press_key(KEY_P);
        expect_true(!status.paused, "paused still high after second press");
        finish_test("pause");

        repeat (3) next_frame();
        press_key(KEY_R);
        expect_true(status.score == 16'd0 && status.kind == '0,
                    $sformatf("restart gave score %0d kind %0d", status.score, status.kind));
        expect_spawn("restart");
        wait_landing(16'd0);
        expect_true(status.kind == piece_kind_t'(1) && status.score == 16'd1,
                    $sformatf("after restart landing kind %0d score %0d",
                    status.kind, status.score));
        finish_test("restart");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* files.f */
hw/blockfall_pkg.sv
hw/vga_timing.sv
hw/block_mover.sv
hw/game_fsm.sv
hw/piece_render.sv
hw/blockfall_top.sv
tb/blockfall_checker.sv
tb/tb_blockfall.sv

/* Bender.yml */
package:
  name: blockfall

sources:
  - files:
      - hw/blockfall_pkg.sv
      - hw/vga_timing.sv
      - hw/block_mover.sv
      - hw/game_fsm.sv
      - hw/piece_render.sv
      - hw/blockfall_top.sv
  - target: test
    files:
      - tb/blockfall_checker.sv
      - tb/tb_blockfall.sv
